// File: include/atari_io_defines.svh
// Sizing constants for the sector buffer, image slots and pointer emulation

`ifndef ATARI_IO_DEFINES_SVH
`define ATARI_IO_DEFINES_SVH

// ========================================
// Sector buffer
// ========================================

// One SD block per transfer
`define ATARI_IO_SECTOR_BYTES 512
`define ATARI_IO_BUF_AW 9

// ========================================
// Disk image slots
// ========================================

// D1 to D4, cart, XEX and boot image
`define ATARI_IO_SLOTS 7

// ========================================
// Pointer emulation
// ========================================

// Largest delta taken from a single mouse packet
`define ATARI_IO_MOUSE_STEP 10

// Saturation bounds of the emulated analog axes
`define ATARI_IO_AXIS_MIN (-128)
`define ATARI_IO_AXIS_MAX 127

`endif

// File: logic/disk_pkg.sv
// Disk bridge types: ZPU control and status, host buffer port, block requests, mount records

`include "atari_io_defines.svh"

package disk_pkg;

	// ========================================
	// ZPU side
	// ========================================

	// Strobes and selects coming out of the ZPU registers
	typedef struct packed {
		logic       lba_sel;
		logic       block_rd;
		logic       block_wr;
		logic [2:0] drive;
		logic       io_wr;
		logic       data_wr;
		logic       data_rd;
	} zpu_ctrl_t;

	// Status byte polled by the firmware, io_done sits in bit 0
	typedef struct packed {
		logic       readonly;
		logic [1:0] filetype;
		logic [2:0] fileno;
		logic       mounted;
		logic       io_done;
	} zpu_status_t;

	// ========================================
	// Host side
	// ========================================

	// Byte access from the SD block service into the sector buffer
	typedef struct packed {
		logic [`ATARI_IO_BUF_AW-1:0] addr;
		logic [7:0]                  wdata;
		logic                        we;
	} host_buf_t;

	// One request bit per slot, all slots share the LBA
	typedef struct packed {
		logic [`ATARI_IO_SLOTS-1:0] rd;
		logic [`ATARI_IO_SLOTS-1:0] wr;
		logic [31:0]                lba;
	} blk_req_t;

	typedef struct packed {
		logic [`ATARI_IO_SLOTS-1:0] mounted;
		logic                       readonly;
		logic [1:0]                 image_type;
		logic [31:0]                size;
	} mount_evt_t;

	// Latest mount as seen by the firmware
	typedef struct packed {
		logic [2:0]  fileno;
		logic [1:0]  filetype;
		logic        readonly;
		logic        toggle;
		logic [31:0] filesize;
	} mount_info_t;

endpackage

// File: logic/input_pkg.sv
// Input types: PS/2 mouse packet, analog axis pair and emulated pointer output

package input_pkg;

	// Host PS/2 mouse word, strobe toggles once per packet
	typedef struct packed {
		logic       strobe;
		logic [6:0] dy;
		logic       spare_dy;
		logic [6:0] dx;
		logic       spare_dx;
		logic [1:0] spare_ovf;
		logic       sign_y;
		logic       sign_x;
		logic [1:0] spare_btn;
		logic [1:0] buttons;
	} mouse_pkt_t;

	// x in the low byte like the host analog word
	typedef struct packed {
		logic signed [7:0] y;
		logic signed [7:0] x;
	} axis_pair_t;

	// What the Atari core sees on port 1
	typedef struct packed {
		axis_pair_t  axes;
		logic [13:0] joy;
	} pointer_t;

endpackage

// File: logic/sector_buffer.sv
// Dual-port sector RAM shared by the SD host and the ZPU

`timescale 1ns/1ns

`include "atari_io_defines.svh"

module sector_buffer
	import disk_pkg::*;
(
	input  logic                        clk_sys,

	// Port A belongs to the host
	input  host_buf_t                   host_i,
	output logic [7:0]                  host_rdata_o,

	// Port B belongs to the ZPU bridge
	input  logic [`ATARI_IO_BUF_AW-1:0] zpu_addr_i,
	input  logic [7:0]                  zpu_wdata_i,
	input  logic                        zpu_we_i,
	output logic [7:0]                  zpu_rdata_o
);

	logic [7:0] mem [`ATARI_IO_SECTOR_BYTES];

	always_ff @(posedge clk_sys) begin
		// Port B goes first so a host write to the same byte lands last
		if (zpu_we_i) begin
			mem[zpu_addr_i] <= zpu_wdata_i;
		end
		if (host_i.we) begin
			mem[host_i.addr] <= host_i.wdata;
		end

		// Registered reads return the old byte on a same-cycle write
		host_rdata_o <= mem[host_i.addr];
		zpu_rdata_o  <= mem[zpu_addr_i];
	end

endmodule

// File: logic/zpu_disk_bridge.sv
// ZPU disk bridge: strobe edge detection, buffer addressing, LBA register, block requests

`timescale 1ns/1ns

`include "atari_io_defines.svh"

module zpu_disk_bridge
	import disk_pkg::*;
(
	input  logic                        clk_sys,
	input  logic                        areset,
	input  zpu_ctrl_t                   ctrl_i,
	input  logic [31:0]                 wdata_i,
	input  mount_info_t                 mount_i,
	input  logic [7:0]                  buf_rdata_i,
	input  logic [`ATARI_IO_SLOTS-1:0]  sd_ack_i,
	output logic [`ATARI_IO_BUF_AW-1:0] buf_addr_o,
	output logic [7:0]                  buf_wdata_o,
	output logic                        buf_we_o,
	output blk_req_t                    req_o,
	output zpu_status_t                 status_o,
	output logic [31:0]                 rdata_o
);

	logic data_wr_q, data_wr_q2, wr_stb;
	logic data_rd_q;
	logic blk_rd_q, blk_rd_q2;
	logic blk_wr_q, blk_wr_q2;
	logic ack_q, ack_q2;
	logic busy, io_done;
	logic [`ATARI_IO_SLOTS-1:0] req_rd, req_wr;
	logic [31:0] lba_q;

	logic wr_rise, rd_fall, blk_rd_rise, blk_wr_rise, ack_any, ack_fall, drive_ok;

	// ========================================
	// Strobe sampling
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			data_wr_q  <= 1'b0;
			data_wr_q2 <= 1'b0;
			wr_stb     <= 1'b0;
			data_rd_q  <= 1'b0;
			blk_rd_q   <= 1'b0;
			blk_rd_q2  <= 1'b0;
			blk_wr_q   <= 1'b0;
			blk_wr_q2  <= 1'b0;
			ack_q      <= 1'b0;
			ack_q2     <= 1'b0;
		end else begin
			data_wr_q  <= ctrl_i.data_wr;
			data_wr_q2 <= data_wr_q;
			wr_stb     <= wr_rise;
			data_rd_q  <= ctrl_i.data_rd;
			blk_rd_q   <= ctrl_i.block_rd;
			blk_rd_q2  <= blk_rd_q;
			blk_wr_q   <= ctrl_i.block_wr;
			blk_wr_q2  <= blk_wr_q;
			ack_q      <= ack_any;
			ack_q2     <= ack_q;
		end
	end

	assign wr_rise     = data_wr_q & ~data_wr_q2;
	assign rd_fall     = data_rd_q & ~ctrl_i.data_rd;
	assign blk_rd_rise = blk_rd_q & ~blk_rd_q2;
	assign blk_wr_rise = blk_wr_q & ~blk_wr_q2;
	assign ack_any     = |sd_ack_i;
	assign ack_fall    = ack_q2 & ~ack_q;
	assign drive_ok    = ctrl_i.drive < 3'(`ATARI_IO_SLOTS);

	// ========================================
	// Buffer port and LBA
	// ========================================

	// Write word goes to the LBA when lba_sel is up, else its low byte to the buffer
	assign buf_we_o    = wr_stb & ~ctrl_i.lba_sel;
	assign buf_wdata_o = wdata_i[7:0];

	always_ff @(posedge clk_sys) begin
		if (wr_stb && ctrl_i.lba_sel) begin
			lba_q <= wdata_i;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			buf_addr_o <= '0;
		end else begin
			if (buf_we_o || rd_fall) begin
				buf_addr_o <= buf_addr_o + 1'b1;
			end
			// io_wr rewinds to the start of the sector
			if (ctrl_i.io_wr) begin
				buf_addr_o <= '0;
			end
		end
	end

	// ========================================
	// Block request handshake
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			req_rd  <= '0;
			req_wr  <= '0;
			io_done <= 1'b0;
			busy    <= 1'b0;
		end else begin
			// New requests only once the previous one has completed
			if (!busy && drive_ok) begin
				if (blk_rd_rise) begin
					req_rd[ctrl_i.drive] <= 1'b1;
					io_done              <= 1'b0;
					busy                 <= 1'b1;
				end else if (blk_wr_rise) begin
					req_wr[ctrl_i.drive] <= 1'b1;
					io_done              <= 1'b0;
					busy                 <= 1'b1;
				end
			end
			if (ack_any) begin
				req_rd <= '0;
				req_wr <= '0;
			end
			if (ack_fall) begin
				io_done <= 1'b1;
				busy    <= 1'b0;
			end
		end
	end

	assign req_o = '{rd: req_rd, wr: req_wr, lba: lba_q};

	// ========================================
	// ZPU read side
	// ========================================

	assign status_o = '{
		readonly: mount_i.readonly,
		filetype: mount_i.filetype,
		fileno:   mount_i.fileno,
		mounted:  mount_i.toggle,
		io_done:  io_done
	};

	assign rdata_o = ctrl_i.lba_sel ? mount_i.filesize : {24'd0, buf_rdata_i};

endmodule

// File: logic/image_mount_tracker.sv
// Image mount tracker: latches slot, type, read-only flag and size of each new mount

`timescale 1ns/1ns

`include "atari_io_defines.svh"

module image_mount_tracker
	import disk_pkg::*;
(
	input  logic        clk_sys,
	input  logic        areset,
	input  mount_evt_t  evt_i,
	output mount_info_t info_o
);

	mount_evt_t evt_q;
	logic any_q, any_q2;
	logic mount_rise;

	// Highest mounted slot wins when several bits are up
	function automatic logic [2:0] top_slot(input logic [`ATARI_IO_SLOTS-1:0] slots);
		logic [2:0] idx;
		idx = '0;
		for (int i = 0; i < `ATARI_IO_SLOTS; i++) begin
			if (slots[i]) begin
				idx = 3'(i);
			end
		end
		return idx;
	endfunction

	always_ff @(posedge clk_sys) begin
		evt_q <= evt_i;
	end

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			any_q  <= 1'b0;
			any_q2 <= 1'b0;
		end else begin
			any_q  <= |evt_i.mounted;
			any_q2 <= any_q;
		end
	end

	assign mount_rise = any_q & ~any_q2;

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			info_o <= '0;
		end else if (mount_rise) begin
			info_o.fileno   <= top_slot(evt_q.mounted);
			info_o.filetype <= evt_q.image_type;
			// Cart and XEX slots are never written back
			info_o.readonly <= evt_q.readonly | evt_q.mounted[4] | evt_q.mounted[5];
			info_o.toggle   <= ~info_o.toggle;
			info_o.filesize <= evt_q.size;
		end
	end

endmodule

// File: logic/pointer_emulator.sv
// Pointer emulator: PS/2 mouse deltas accumulated into saturated analog joystick axes

`timescale 1ns/1ns

`include "atari_io_defines.svh"

module pointer_emulator
	import input_pkg::*;
(
	input  logic        clk_sys,
	input  logic        areset,
	input  mouse_pkt_t  mouse_i,
	input  axis_pair_t  analog_i,
	input  logic [13:0] joy_i,
	input  logic        invert_y_i,
	input  logic        cpu_halt_i,
	output pointer_t    pointer_o
);

	localparam logic signed [8:0] STEP_MAX = 9'(`ATARI_IO_MOUSE_STEP);
	localparam logic signed [8:0] AXIS_MIN = 9'(`ATARI_IO_AXIS_MIN);
	localparam logic signed [8:0] AXIS_MAX = 9'(`ATARI_IO_AXIS_MAX);

	mouse_pkt_t pkt_q;
	logic stb_q, stb_q2;
	logic emu;
	logic signed [7:0] mx, my;
	logic signed [8:0] step_x, step_y, next_x, next_y;

	// Sign-extend a 7-bit delta and limit it to one step
	function automatic logic signed [8:0] clamp_step(input logic sign, input logic [6:0] mag);
		logic signed [8:0] d;
		d = {sign, sign, mag};
		if (d > STEP_MAX) begin
			d = STEP_MAX;
		end else if (d < -STEP_MAX) begin
			d = -STEP_MAX;
		end
		return d;
	endfunction

	function automatic logic signed [7:0] saturate(input logic signed [8:0] v);
		logic signed [8:0] r;
		r = v;
		if (v < AXIS_MIN) begin
			r = AXIS_MIN;
		end else if (v > AXIS_MAX) begin
			r = AXIS_MAX;
		end
		return r[7:0];
	endfunction

	always_ff @(posedge clk_sys) begin
		pkt_q <= mouse_i;
	end

	assign step_x = clamp_step(pkt_q.sign_x, pkt_q.dx);
	assign step_y = clamp_step(pkt_q.sign_y, pkt_q.dy);
	assign next_x = 9'(mx) + step_x;
	assign next_y = invert_y_i ? (9'(my) - step_y) : (9'(my) + step_y);

	always_ff @(posedge clk_sys) begin
		if (areset) begin
			stb_q  <= 1'b0;
			stb_q2 <= 1'b0;
			emu    <= 1'b0;
			mx     <= '0;
			my     <= '0;
		end else begin
			stb_q  <= mouse_i.strobe;
			stb_q2 <= stb_q;
			if (stb_q != stb_q2) begin
				emu <= 1'b1;
				mx  <= saturate(next_x);
				my  <= saturate(next_y);
			end
			// A real stick or a halted CPU takes the port back
			if (analog_i != '0 || cpu_halt_i) begin
				emu <= 1'b0;
				mx  <= '0;
				my  <= '0;
			end
		end
	end

	assign pointer_o.axes = emu ? '{y: my, x: mx} : analog_i;
	assign pointer_o.joy  = {joy_i[13:9], emu ? pkt_q.buttons : joy_i[8:7], joy_i[6:0]};

endmodule

// File: logic/atari_io_top.sv
// Top level of the Atari I/O block: disk bridge, sector buffer, mount tracker, pointer emulator

`timescale 1ns/1ns

`include "atari_io_defines.svh"

module atari_io_top
	import disk_pkg::*;
	import input_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       areset,

	// ZPU firmware registers
	input  zpu_ctrl_t                  zpu_ctrl_i,
	input  logic [31:0]                zpu_wdata_i,
	output zpu_status_t                zpu_status_o,
	output logic [31:0]                zpu_rdata_o,

	// SD host block service
	input  host_buf_t                  host_buf_i,
	output logic [7:0]                 host_rdata_o,
	output blk_req_t                   sd_req_o,
	input  logic [`ATARI_IO_SLOTS-1:0] sd_ack_i,
	input  mount_evt_t                 mount_i,

	// Pointer inputs and joystick port
	input  mouse_pkt_t                 mouse_i,
	input  axis_pair_t                 analog_i,
	input  logic [13:0]                joy_i,
	input  logic                       invert_y_i,
	input  logic                       cpu_halt_i,
	output pointer_t                   pointer_o
);

	logic [`ATARI_IO_BUF_AW-1:0] buf_addr;
	logic [7:0]                  buf_wdata;
	logic                        buf_we;
	logic [7:0]                  buf_rdata;
	mount_info_t                 mount_info;

	sector_buffer u_sector_buffer (
		.clk_sys      (clk_sys),
		.host_i       (host_buf_i),
		.host_rdata_o (host_rdata_o),
		.zpu_addr_i   (buf_addr),
		.zpu_wdata_i  (buf_wdata),
		.zpu_we_i     (buf_we),
		.zpu_rdata_o  (buf_rdata)
	);

	zpu_disk_bridge u_zpu_disk_bridge (
		.clk_sys     (clk_sys),
		.areset      (areset),
		.ctrl_i      (zpu_ctrl_i),
		.wdata_i     (zpu_wdata_i),
		.mount_i     (mount_info),
		.buf_rdata_i (buf_rdata),
		.sd_ack_i    (sd_ack_i),
		.buf_addr_o  (buf_addr),
		.buf_wdata_o (buf_wdata),
		.buf_we_o    (buf_we),
		.req_o       (sd_req_o),
		.status_o    (zpu_status_o),
		.rdata_o     (zpu_rdata_o)
	);

	image_mount_tracker u_image_mount_tracker (
		.clk_sys (clk_sys),
		.areset  (areset),
		.evt_i   (mount_i),
		.info_o  (mount_info)
	);

	pointer_emulator u_pointer_emulator (
		.clk_sys    (clk_sys),
		.areset     (areset),
		.mouse_i    (mouse_i),
		.analog_i   (analog_i),
		.joy_i      (joy_i),
		.invert_y_i (invert_y_i),
		.cpu_halt_i (cpu_halt_i),
		.pointer_o  (pointer_o)
	);

endmodule

// File: tests/atari_io_properties.sv
// Concurrent assertions on the block request handshake and reset state of the top level

`timescale 1ns/1ns

`include "atari_io_defines.svh"

module atari_io_properties
	import disk_pkg::*;
(
	input  logic                       clk_sys,
	input  logic                       areset,
	input  blk_req_t                   req_i,
	input  logic [`ATARI_IO_SLOTS-1:0] ack_i,
	input  zpu_status_t                status_i
);

	logic req_any;
	logic ack_any;

	assign req_any = (req_i.rd != '0) || (req_i.wr != '0);
	assign ack_any = (ack_i != '0);

	// ========================================
	// Handshake rules
	// ========================================

	// Request bits come out of reset cleared
	property reset_clears_req;
		@(posedge clk_sys) areset |=> !req_any;
	endproperty

	// One drive and one direction at a time
	property single_request;
		@(posedge clk_sys) disable iff (areset) $onehot0({req_i.rd, req_i.wr});
	endproperty

	// The bridge drops its request as soon as the host acks
	property req_drops_on_ack;
		@(posedge clk_sys) disable iff (areset) ack_any |=> !req_any;
	endproperty

	// Completion only after the host has released ack
	property done_after_ack;
		@(posedge clk_sys) disable iff (areset) $rose(status_i.io_done) |-> !ack_any;
	endproperty

	assert property (reset_clears_req) else $error("Request bits set after reset");
	assert property (single_request) else $error("More than one request bit set");
	assert property (req_drops_on_ack) else $error("Request still high after ack");
	assert property (done_after_ack) else $error("io_done rose while ack was high");

endmodule

// File: tests/atari_io_tb.sv
// Atari I/O testbench with clock, reset, watchdog, directed tests and checks

`timescale 1ns/1ns

`include "atari_io_defines.svh"

module atari_io_tb
	import disk_pkg::*;
	import input_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	localparam int NUM_BYTES  = 16;

	// Rough cycle budget of each test
	localparam int BUFFER_CYCLES  = 160;
	localparam int REQUEST_CYCLES = 60;
	localparam int MOUNT_CYCLES   = 30;
	localparam int POINTER_CYCLES = 40;
	localparam int OVERRIDE_CYCLES = 20;
	localparam int TEST_CYCLES = BUFFER_CYCLES + REQUEST_CYCLES + MOUNT_CYCLES
		+ POINTER_CYCLES + OVERRIDE_CYCLES;
	localparam int WATCHDOG_NS = TEST_CYCLES * 4 * CLK_PERIOD;

	logic                       clk_sys;
	logic                       areset;
	zpu_ctrl_t                  zpu_ctrl;
	logic [31:0]                zpu_wdata;
	zpu_status_t                zpu_status;
	logic [31:0]                zpu_rdata;
	host_buf_t                  host_buf;
	logic [7:0]                 host_rdata;
	blk_req_t                   sd_req;
	logic [`ATARI_IO_SLOTS-1:0] sd_ack;
	mount_evt_t                 mount_evt;
	mouse_pkt_t                 mouse;
	axis_pair_t                 analog;
	logic [13:0]                joy;
	logic                       invert_y;
	logic                       cpu_halt;
	pointer_t                   pointer;

	integer     seed;
	int         errors;
	int         checks;
	logic [7:0] exp_bytes [NUM_BYTES];
	// Reference position of the emulated pointer
	int         acc_x;
	int         acc_y;

	always #(CLK_PERIOD / 2) clk_sys = ~clk_sys;

	atari_io_top dut_i (
		.clk_sys      (clk_sys),
		.areset       (areset),
		.zpu_ctrl_i   (zpu_ctrl),
		.zpu_wdata_i  (zpu_wdata),
		.zpu_status_o (zpu_status),
		.zpu_rdata_o  (zpu_rdata),
		.host_buf_i   (host_buf),
		.host_rdata_o (host_rdata),
		.sd_req_o     (sd_req),
		.sd_ack_i     (sd_ack),
		.mount_i      (mount_evt),
		.mouse_i      (mouse),
		.analog_i     (analog),
		.joy_i        (joy),
		.invert_y_i   (invert_y),
		.cpu_halt_i   (cpu_halt),
		.pointer_o    (pointer)
	);

	bind atari_io_top atari_io_properties props_i (
		.clk_sys  (clk_sys),
		.areset   (areset),
		.req_i    (sd_req_o),
		.ack_i    (sd_ack_i),
		.status_i (zpu_status_o)
	);

	// ========================================
	// Compare tasks
	// ========================================

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %02h expected %02h", $time, what, got, exp);
		end
	endtask

	task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %08h expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic check_req(input blk_req_t got, input blk_req_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got rd %b wr %b lba %08h", $time, what,
				got.rd, got.wr, got.lba);
			$display("  expected rd %b wr %b lba %08h", exp.rd, exp.wr, exp.lba);
		end
	endtask

	task automatic check_status(input zpu_status_t got, input zpu_status_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got %08b expected %08b", $time, what, got, exp);
		end
	endtask

	task automatic check_pointer(input pointer_t got, input pointer_t exp, input string what);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t ns: %s got x %0d y %0d joy %014b", $time, what,
				got.axes.x, got.axes.y, got.joy);
			$display("  expected x %0d y %0d joy %014b", exp.axes.x, exp.axes.y, exp.joy);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("Error at %0t ns: %s", $time, msg);
	endtask

	task automatic report_test(input string name, input int start);
		$display("Test %s finished with %0d errors", name, errors - start);
	endtask

	// ========================================
	// Bus drivers
	// ========================================

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	task automatic host_write(input logic [8:0] addr, input logic [7:0] data);
		host_buf = '{addr: addr, wdata: data, we: 1'b1};
		wait_cycles(1);
		host_buf.we = 1'b0;
	endtask

	task automatic host_read(input logic [8:0] addr, output logic [7:0] data);
		host_buf = '{addr: addr, wdata: 8'h00, we: 1'b0};
		wait_cycles(1);
		data = host_rdata;
	endtask

	// io_wr pulse puts the buffer pointer back on byte 0
	task automatic zpu_rewind();
		zpu_ctrl.io_wr = 1'b1;
		wait_cycles(1);
		zpu_ctrl.io_wr = 1'b0;
		wait_cycles(1);
	endtask

	task automatic zpu_write(input logic lba_sel, input logic [31:0] data);
		zpu_ctrl.lba_sel = lba_sel;
		zpu_wdata = data;
		zpu_ctrl.data_wr = 1'b1;
		wait_cycles(1);
		zpu_ctrl.data_wr = 1'b0;
		wait_cycles(3);
	endtask

	// Take the current byte, then step to the next one
	task automatic zpu_read_next(output logic [31:0] data);
		data = zpu_rdata;
		zpu_ctrl.data_rd = 1'b1;
		wait_cycles(1);
		zpu_ctrl.data_rd = 1'b0;
		wait_cycles(2);
	endtask

	task automatic wait_request(output logic seen);
		seen = 1'b0;
		for (int i = 0; i < 10 && !seen; i++) begin
			wait_cycles(1);
			seen = (sd_req.rd != '0) || (sd_req.wr != '0);
		end
	endtask

	task automatic wait_done(output logic seen);
		seen = 1'b0;
		for (int i = 0; i < 20 && !seen; i++) begin
			wait_cycles(1);
			seen = zpu_status.io_done;
		end
	endtask

	task automatic mount_image(input logic [6:0] slots, input logic ro, input logic [1:0] kind,
			input logic [31:0] size, output logic seen);
		logic old_toggle;
		old_toggle = zpu_status.mounted;
		mount_evt = '{mounted: slots, readonly: ro, image_type: kind, size: size};
		seen = 1'b0;
		for (int i = 0; i < 10 && !seen; i++) begin
			wait_cycles(1);
			seen = (zpu_status.mounted != old_toggle);
		end
		mount_evt.mounted = '0;
		wait_cycles(3);
	endtask

	// ========================================
	// Pointer reference model
	// ========================================

	function automatic int limit_step(input int d);
		if (d > `ATARI_IO_MOUSE_STEP) begin
			return `ATARI_IO_MOUSE_STEP;
		end else if (d < -`ATARI_IO_MOUSE_STEP) begin
			return -`ATARI_IO_MOUSE_STEP;
		end
		return d;
	endfunction

	function automatic int limit_axis(input int v);
		if (v > `ATARI_IO_AXIS_MAX) begin
			return `ATARI_IO_AXIS_MAX;
		end else if (v < `ATARI_IO_AXIS_MIN) begin
			return `ATARI_IO_AXIS_MIN;
		end
		return v;
	endfunction

	task automatic send_and_check(input int dx, input int dy, input logic inv,
			input logic [1:0] buttons);
		pointer_t exp;
		mouse.dx = 7'(dx);
		mouse.sign_x = (dx < 0);
		mouse.dy = 7'(dy);
		mouse.sign_y = (dy < 0);
		mouse.buttons = buttons;
		invert_y = inv;
		mouse.strobe = ~mouse.strobe;
		wait_cycles(2);
		acc_x = limit_axis(acc_x + limit_step(dx));
		if (inv) begin
			acc_y = limit_axis(acc_y - limit_step(dy));
		end else begin
			acc_y = limit_axis(acc_y + limit_step(dy));
		end
		exp.axes.x = 8'(acc_x);
		exp.axes.y = 8'(acc_y);
		exp.joy = {joy[13:9], buttons, joy[6:0]};
		check_pointer(pointer, exp, "pointer after mouse packet");
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic test_buffer_loop();
		logic [7:0]  got;
		logic [31:0] rd_word;
		logic [31:0] wr_word;
		int          start;
		start = errors;
		for (int i = 0; i < NUM_BYTES; i++) begin
			exp_bytes[i] = 8'($random(seed));
			host_write(9'(i), exp_bytes[i]);
		end
		zpu_rewind();
		for (int i = 0; i < NUM_BYTES; i++) begin
			zpu_read_next(rd_word);
			check_word(rd_word, {24'd0, exp_bytes[i]}, "ZPU read of host byte");
		end
		zpu_rewind();
		for (int i = 0; i < NUM_BYTES; i++) begin
			wr_word = $random(seed);
			exp_bytes[i] = wr_word[7:0];
			zpu_write(1'b0, wr_word);
		end
		for (int i = 0; i < NUM_BYTES; i++) begin
			host_read(9'(i), got);
			check_byte(got, exp_bytes[i], "host read of ZPU byte");
		end
		report_test("buffer_loop", start);
	endtask

	task automatic run_block(input logic is_wr, input logic [31:0] lba);
		blk_req_t    exp_req;
		zpu_status_t exp_st;
		logic        seen;
		int          hold;
		zpu_ctrl.drive = 3'd3;
		if (is_wr) begin
			zpu_ctrl.block_wr = 1'b1;
		end else begin
			zpu_ctrl.block_rd = 1'b1;
		end
		wait_cycles(1);
		zpu_ctrl.block_rd = 1'b0;
		zpu_ctrl.block_wr = 1'b0;
		wait_request(seen);
		if (!seen) begin
			report_failure("no block request appeared after the ZPU strobe");
		end
		exp_req = '{rd: '0, wr: '0, lba: lba};
		if (is_wr) begin
			exp_req.wr[3] = 1'b1;
		end else begin
			exp_req.rd[3] = 1'b1;
		end
		exp_st = '0;
		check_req(sd_req, exp_req, "pending block request");
		check_status(zpu_status, exp_st, "status while request pending");
		sd_ack = 7'b0001000;
		wait_cycles(1);
		exp_req = '{rd: '0, wr: '0, lba: lba};
		check_req(sd_req, exp_req, "request after ack");
		hold = 1 + ($random(seed) & 7);
		wait_cycles(hold);
		check_status(zpu_status, exp_st, "status while ack held");
		sd_ack = '0;
		wait_done(seen);
		if (!seen) begin
			report_failure("io_done did not rise after ack was released");
		end
		exp_st.io_done = 1'b1;
		check_status(zpu_status, exp_st, "status after completion");
	endtask

	task automatic test_block_request();
		logic [31:0] lba;
		int          start;
		start = errors;
		lba = $random(seed);
		// lba_sel stays high through both requests
		zpu_write(1'b1, lba);
		run_block(1'b0, lba);
		run_block(1'b1, lba);
		zpu_ctrl.lba_sel = 1'b0;
		report_test("block_request", start);
	endtask

	task automatic test_mount_events();
		logic [31:0] size;
		zpu_status_t exp;
		logic        seen;
		int          start;
		start = errors;
		size = $random(seed);
		// Slot 5 is read-only even with the flag low
		mount_image(7'b0100000, 1'b0, 2'd2, size, seen);
		if (!seen) begin
			report_failure("mount toggle did not change after the slot 5 mount");
		end
		exp = '{readonly: 1'b1, filetype: 2'd2, fileno: 3'd5, mounted: 1'b1, io_done: 1'b1};
		check_status(zpu_status, exp, "status after slot 5 mount");
		zpu_ctrl.lba_sel = 1'b1;
		wait_cycles(1);
		check_word(zpu_rdata, size, "file size of slot 5");
		zpu_ctrl.lba_sel = 1'b0;
		size = $random(seed);
		mount_image(7'b0000010, 1'b0, 2'd1, size, seen);
		if (!seen) begin
			report_failure("mount toggle did not change after the slot 1 mount");
		end
		exp = '{readonly: 1'b0, filetype: 2'd1, fileno: 3'd1, mounted: 1'b0, io_done: 1'b1};
		check_status(zpu_status, exp, "status after slot 1 mount");
		zpu_ctrl.lba_sel = 1'b1;
		wait_cycles(1);
		check_word(zpu_rdata, size, "file size of slot 1");
		zpu_ctrl.lba_sel = 1'b0;
		report_test("mount_events", start);
	endtask

	task automatic test_mouse_steps();
		pointer_t exp;
		int       start;
		start = errors;
		acc_x = 0;
		acc_y = 0;
		joy = 14'($random(seed));
		send_and_check(40, -3, 1'b0, 2'b01);
		send_and_check(-3, 40, 1'b1, 2'b01);
		// Long run drives x to the top and inverted y to the bottom
		for (int i = 0; i < 16; i++) begin
			send_and_check(40, 40, 1'b1, 2'b10);
		end
		exp.axes.x = 8'(`ATARI_IO_AXIS_MAX);
		exp.axes.y = 8'(`ATARI_IO_AXIS_MIN);
		exp.joy = {joy[13:9], 2'b10, joy[6:0]};
		check_pointer(pointer, exp, "pointer at both axis limits");
		report_test("mouse_steps", start);
	endtask

	task automatic test_pointer_override();
		pointer_t exp;
		int       start;
		start = errors;
		// x = 35, y = -20
		analog = '{y: 8'hec, x: 8'h23};
		wait_cycles(2);
		exp = '{axes: analog, joy: joy};
		check_pointer(pointer, exp, "analog stick override");
		analog = '0;
		acc_x = 0;
		acc_y = 0;
		wait_cycles(1);
		exp = '{axes: '0, joy: joy};
		check_pointer(pointer, exp, "released analog stick");
		send_and_check(5, 2, 1'b0, 2'b11);
		cpu_halt = 1'b1;
		wait_cycles(2);
		check_pointer(pointer, exp, "CPU halt override");
		cpu_halt = 1'b0;
		acc_x = 0;
		acc_y = 0;
		send_and_check(-4, 1, 1'b0, 2'b01);
		report_test("pointer_override", start);
	endtask

	// ========================================
	// Run control
	// ========================================

	initial begin
		#(WATCHDOG_NS);
		$display("Watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		clk_sys = 1'b0;
		areset = 1'b1;
		seed = 32'h1cac_abfd;
		errors = 0;
		checks = 0;
		zpu_ctrl = '0;
		zpu_wdata = '0;
		host_buf = '0;
		sd_ack = '0;
		mount_evt = '0;
		mouse = '0;
		analog = '0;
		joy = '0;
		invert_y = 1'b0;
		cpu_halt = 1'b0;
		wait_cycles(3);
		areset = 1'b0;
		wait_cycles(1);
		test_buffer_loop();
		test_block_request();
		test_mount_events();
		test_mouse_steps();
		test_pointer_override();
		$display("Summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: atari_io_top.f
+incdir+include
logic/disk_pkg.sv
logic/input_pkg.sv
logic/sector_buffer.sv
logic/zpu_disk_bridge.sv
logic/image_mount_tracker.sv
logic/pointer_emulator.sv
logic/atari_io_top.sv
tests/atari_io_properties.sv
tests/atari_io_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := atari_io_tb
FILELIST  := atari_io_top.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q -F '*** PASSED ***' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
